// ==== hdl/io_pkg.sv ====
package io_pkg;

    // Hardware thread count, sets enable and pending widths
    localparam int TOTAL_THREADS = 4;

    // Source 0 is the interval timer, source 1 the external pin
    localparam int NUM_INT_SOURCES = 2;

    // I/O bus address and data words
    typedef logic [15:0] io_addr_t;
    typedef logic [31:0] io_data_t;

    // Interrupt controller register offsets from its base
    typedef enum io_addr_t
    {
        // Write sets enable bits, read returns enable mask
        RESUME = 16'd0,
        // Write clears enable bits
        HALT = 16'd4,
        // One bit per source, 1 selects level
        TRIGGER = 16'd8,
        // Write clears latch bits
        ACK = 16'd12,
        // Read returns latch bits
        PENDING = 16'd16
    } ic_reg_t;

    // Interval timer register offsets from its base
    typedef enum io_addr_t
    {
        // Write loads reload value and counter
        RELOAD = 16'd0,
        // Current counter, read only
        COUNT = 16'd4,
        // Bit 0 enable, bit 1 periodic
        CONTROL = 16'd8
    } timer_reg_t;

endpackage

// ==== hdl/io_bus_if.sv ====
`timescale 1ns/1ps

// One I/O bus between the arbiter and a single peripheral
interface io_bus_if;
    import io_pkg::*;

    // Strobes, one cycle per transaction
    logic write_en;
    logic read_en;
    io_addr_t address;
    io_data_t write_data;

    // Zero unless this peripheral is addressed by a read
    io_data_t read_data;

    // Arbiter side
    modport master(output write_en, output read_en, output address,
        output write_data, input read_data);

    // Peripheral side
    modport slave(input write_en, input read_en, input address,
        input write_data, output read_data);

endinterface

// ==== hdl/io_arbiter.sv ====
`timescale 1ns/1ps

module io_arbiter
    #(parameter int NUM_MASTERS = 2)
    (input                                  clk,
    input                                   reset,

    // Processor request ports
    input [NUM_MASTERS - 1:0]               io_request,
    input [NUM_MASTERS - 1:0]               io_store,
    input io_pkg::io_addr_t                 io_address[NUM_MASTERS],
    input io_pkg::io_data_t                 io_store_data[NUM_MASTERS],
    output logic [NUM_MASTERS - 1:0]        io_grant,
    output logic [NUM_MASTERS - 1:0]        io_response_valid,
    output io_pkg::io_data_t                io_read_data[NUM_MASTERS],

    // Peripheral buses, same request driven onto both
    io_bus_if.master                        ic_bus,
    io_bus_if.master                        timer_bus);

    import io_pkg::*;

    localparam int IDX_WIDTH = NUM_MASTERS > 1 ? $clog2(NUM_MASTERS) : 1;

    logic [IDX_WIDTH - 1:0] rr_ptr;
    logic [IDX_WIDTH - 1:0] grant_idx;
    logic grant_valid;
    // Master that owns the request now on the buses
    logic [IDX_WIDTH - 1:0] bus_idx;
    logic bus_valid;
    logic bus_write_en;
    logic bus_read_en;
    io_addr_t bus_address;
    io_data_t bus_write_data;
    io_data_t combined_read_data;

    // Search from the pointer, first requester wins
    always_comb
    begin : grant_search
        int candidate;

        grant_valid = 1'b0;
        grant_idx = rr_ptr;
        for (int i = 0; i < NUM_MASTERS; i++)
        begin
            candidate = int'(rr_ptr) + i;
            if (candidate >= NUM_MASTERS)
                candidate -= NUM_MASTERS;

            if (!grant_valid && io_request[candidate])
            begin
                grant_valid = 1'b1;
                grant_idx = IDX_WIDTH'(candidate);
            end
        end

        io_grant = '0;
        if (grant_valid)
            io_grant[grant_idx] = 1'b1;
    end

    // Peripherals only return data when addressed, so OR is safe
    assign combined_read_data = ic_bus.read_data | timer_bus.read_data;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            rr_ptr <= '0;
            bus_valid <= 1'b0;
            bus_write_en <= 1'b0;
            bus_read_en <= 1'b0;
            io_response_valid <= '0;
        end
        else
        begin
            // Stage 1, granted request onto the buses
            bus_valid <= grant_valid;
            bus_write_en <= grant_valid && io_store[grant_idx];
            bus_read_en <= grant_valid && !io_store[grant_idx];

            // Move past the granted port
            if (grant_valid)
                rr_ptr <= int'(grant_idx) == NUM_MASTERS - 1 ? '0 : grant_idx + 1'b1;

            // Stage 2, response pulse for the owner
            io_response_valid <= '0;
            if (bus_valid)
                io_response_valid[bus_idx] <= 1'b1;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            bus_idx <= grant_idx;
            bus_address <= io_address[grant_idx];
            bus_write_data <= io_store_data[grant_idx];
        end

        if (bus_valid)
            io_read_data[bus_idx] <= combined_read_data;
    end

    assign ic_bus.write_en = bus_write_en;
    assign ic_bus.read_en = bus_read_en;
    assign ic_bus.address = bus_address;
    assign ic_bus.write_data = bus_write_data;
    assign timer_bus.write_en = bus_write_en;
    assign timer_bus.read_en = bus_read_en;
    assign timer_bus.address = bus_address;
    assign timer_bus.write_data = bus_write_data;

endmodule

// ==== hdl/interrupt_controller.sv ====
`timescale 1ns/1ps

module interrupt_controller
    #(parameter io_pkg::io_addr_t BASE_ADDRESS = '0)
    (input                                          clk,
    input                                           reset,

    // Register access
    io_bus_if.slave                                 io_bus,

    // Source 0 timer, source 1 external pin
    input [io_pkg::NUM_INT_SOURCES - 1:0]           interrupt_req,

    // To threads
    output logic [io_pkg::TOTAL_THREADS - 1:0]      ic_thread_en,
    output logic [io_pkg::TOTAL_THREADS - 1:0]      ic_interrupt_pending,
    output logic                                    processor_halt);

    import io_pkg::*;

    io_addr_t offset;
    ic_reg_t reg_sel;
    // One bit per source, 1 means level
    logic [NUM_INT_SOURCES - 1:0] trigger_mask;
    logic [NUM_INT_SOURCES - 1:0] int_latched;
    logic [NUM_INT_SOURCES - 1:0] ack_mask;
    logic [NUM_INT_SOURCES - 1:0] source_active;

    // Wraps below base, so only the local window decodes
    assign offset = io_bus.address - BASE_ADDRESS;
    assign reg_sel = ic_reg_t'(offset);

    // Bits cleared by an ACK write this cycle
    assign ack_mask = io_bus.write_en && reg_sel == ACK
        ? io_bus.write_data[NUM_INT_SOURCES - 1:0] : '0;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            // Thread 0 runs out of reset
            ic_thread_en <= TOTAL_THREADS'(1);
            trigger_mask <= '0;
            int_latched <= '0;
        end
        else
        begin
            if (io_bus.write_en)
            begin
                case (reg_sel)
                    RESUME:
                        ic_thread_en <= ic_thread_en | io_bus.write_data[TOTAL_THREADS - 1:0];

                    HALT:
                        ic_thread_en <= ic_thread_en & ~io_bus.write_data[TOTAL_THREADS - 1:0];

                    TRIGGER:
                        trigger_mask <= io_bus.write_data[NUM_INT_SOURCES - 1:0];

                    default:
                        ;
                endcase
            end

            // Edge sources latch; new request beats a same-cycle ack
            int_latched <= (int_latched & ~ack_mask) | (interrupt_req & ~trigger_mask);
        end
    end

    // Level sources live, edge sources from the latch
    assign source_active = (trigger_mask & interrupt_req) | (~trigger_mask & int_latched);

    // Dispatch only to thread 0
    always_comb
    begin
        ic_interrupt_pending = '0;
        ic_interrupt_pending[0] = |source_active;
    end

    assign processor_halt = ic_thread_en == '0;

    // Zero when not addressed or not a read
    always_comb
    begin
        io_bus.read_data = '0;
        if (io_bus.read_en)
        begin
            case (reg_sel)
                RESUME:
                    io_bus.read_data = io_data_t'(ic_thread_en);

                TRIGGER:
                    io_bus.read_data = io_data_t'(trigger_mask);

                PENDING:
                    io_bus.read_data = io_data_t'(int_latched);

                default:
                    io_bus.read_data = '0;
            endcase
        end
    end

endmodule

// ==== hdl/interval_timer.sv ====
`timescale 1ns/1ps

module interval_timer
    #(parameter io_pkg::io_addr_t BASE_ADDRESS = '0)
    (input              clk,
    input               reset,

    // Register access
    io_bus_if.slave     io_bus,

    // One-cycle pulse at expiry
    output logic        expire);

    import io_pkg::*;

    io_addr_t offset;
    timer_reg_t reg_sel;
    io_data_t reload_value;
    io_data_t counter;
    logic timer_en;
    logic periodic;

    assign offset = io_bus.address - BASE_ADDRESS;
    assign reg_sel = timer_reg_t'(offset);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            counter <= '0;
            timer_en <= 1'b0;
            periodic <= 1'b0;
            expire <= 1'b0;
        end
        else
        begin
            expire <= 1'b0;
            if (timer_en)
            begin
                // Last count, pulse and reload or stop
                if (counter <= io_data_t'(1))
                begin
                    expire <= 1'b1;
                    counter <= periodic ? reload_value : '0;
                    if (!periodic)
                        timer_en <= 1'b0;
                end
                else
                    counter <= counter - 1'b1;
            end

            // Bus writes override the count
            if (io_bus.write_en && reg_sel == RELOAD)
                counter <= io_bus.write_data;

            if (io_bus.write_en && reg_sel == CONTROL)
            begin
                timer_en <= io_bus.write_data[0];
                periodic <= io_bus.write_data[1];
            end
        end
    end

    // Reload value, no reset
    always_ff @(posedge clk)
    begin
        if (io_bus.write_en && reg_sel == RELOAD)
            reload_value <= io_bus.write_data;
    end

    always_comb
    begin
        io_bus.read_data = '0;
        if (io_bus.read_en)
        begin
            case (reg_sel)
                RELOAD:
                    io_bus.read_data = reload_value;

                COUNT:
                    io_bus.read_data = counter;

                CONTROL:
                    io_bus.read_data = {30'd0, periodic, timer_en};

                default:
                    io_bus.read_data = '0;
            endcase
        end
    end

endmodule

// ==== hdl/io_subsystem.sv ====
`timescale 1ns/1ps

module io_subsystem
    #(parameter int NUM_MASTERS = 2,
    parameter io_pkg::io_addr_t IC_BASE = 16'h0100,
    parameter io_pkg::io_addr_t TIMER_BASE = 16'h0200)
    (input                                          clk,
    input                                           reset,

    // Processor request ports
    input [NUM_MASTERS - 1:0]                       io_request,
    input [NUM_MASTERS - 1:0]                       io_store,
    input io_pkg::io_addr_t                         io_address[NUM_MASTERS],
    input io_pkg::io_data_t                         io_store_data[NUM_MASTERS],
    output logic [NUM_MASTERS - 1:0]                io_grant,
    output logic [NUM_MASTERS - 1:0]                io_response_valid,
    output io_pkg::io_data_t                        io_read_data[NUM_MASTERS],

    // Interrupt pin from outside
    input                                           external_interrupt,

    // To threads
    output logic [io_pkg::TOTAL_THREADS - 1:0]      ic_thread_en,
    output logic [io_pkg::TOTAL_THREADS - 1:0]      ic_interrupt_pending,
    output logic                                    processor_halt);

    import io_pkg::*;

    logic timer_expire;
    logic [NUM_INT_SOURCES - 1:0] interrupt_req;

    // One bus per peripheral
    io_bus_if ic_bus();
    io_bus_if timer_bus();

    // Timer on source 0, pin on source 1
    assign interrupt_req = {external_interrupt, timer_expire};

    io_arbiter #(
        .NUM_MASTERS(NUM_MASTERS)
    ) arbiter (
        .clk(clk),
        .reset(reset),
        .io_request(io_request),
        .io_store(io_store),
        .io_address(io_address),
        .io_store_data(io_store_data),
        .io_grant(io_grant),
        .io_response_valid(io_response_valid),
        .io_read_data(io_read_data),
        .ic_bus(ic_bus.master),
        .timer_bus(timer_bus.master)
    );

    interrupt_controller #(
        .BASE_ADDRESS(IC_BASE)
    ) ic (
        .clk(clk),
        .reset(reset),
        .io_bus(ic_bus.slave),
        .interrupt_req(interrupt_req),
        .ic_thread_en(ic_thread_en),
        .ic_interrupt_pending(ic_interrupt_pending),
        .processor_halt(processor_halt)
    );

    interval_timer #(
        .BASE_ADDRESS(TIMER_BASE)
    ) timer (
        .clk(clk),
        .reset(reset),
        .io_bus(timer_bus.slave),
        .expire(timer_expire)
    );

endmodule

// ==== testbench/io_subsystem_asserts.sv ====
`timescale 1ns/1ps

module io_subsystem_asserts
    #(parameter int NUM_MASTERS = 2,
    parameter bit CHECK_ARBITER = 1'b1)
    (input                                  clk,
    input                                   reset,
    input [NUM_MASTERS - 1:0]               grant,
    input [NUM_MASTERS - 1:0]               response_valid,
    input [io_pkg::TOTAL_THREADS - 1:0]     thread_en,
    input [io_pkg::TOTAL_THREADS - 1:0]     pending,
    input                                   halt);

    import io_pkg::*;

    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    if (CHECK_ARBITER)
    begin : arbiter_checks
        // At most one port granted
        assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
            else
            begin
                fail_count++;
                $error("more than one grant in a cycle");
            end

        // Response two cycles after each grant
        for (genvar m = 0; m < NUM_MASTERS; m++)
        begin : per_port
            assert property (@(posedge clk) disable iff (reset)
                grant[m] |-> ##2 response_valid[m])
                else
                begin
                    fail_count++;
                    $error("no response two cycles after grant");
                end
        end
    end
    else
    begin : controller_checks
        assert property (@(posedge clk) disable iff (reset) halt == (thread_en == '0))
            else
            begin
                fail_count++;
                $error("processor_halt does not match enable mask");
            end

        // Only thread 0 takes interrupts
        assert property (@(posedge clk) disable iff (reset)
            pending[TOTAL_THREADS - 1:1] == '0)
            else
            begin
                fail_count++;
                $error("interrupt pending on thread other than 0");
            end
    end

endmodule

bind io_arbiter io_subsystem_asserts #(
    .NUM_MASTERS(NUM_MASTERS),
    .CHECK_ARBITER(1'b1)
) arbiter_asserts (
    .clk(clk),
    .reset(reset),
    .grant(io_grant),
    .response_valid(io_response_valid),
    .thread_en(io_pkg::TOTAL_THREADS'(1)),
    .pending('0),
    .halt(1'b0)
);

bind interrupt_controller io_subsystem_asserts #(
    .NUM_MASTERS(2),
    .CHECK_ARBITER(1'b0)
) controller_asserts (
    .clk(clk),
    .reset(reset),
    .grant('0),
    .response_valid('0),
    .thread_en(ic_thread_en),
    .pending(ic_interrupt_pending),
    .halt(processor_halt)
);

// ==== testbench/io_subsystem_tb.sv ====
`timescale 1ns/1ps

module io_subsystem_tb;

    import io_pkg::*;

    localparam int NUM_MASTERS = 2;
    localparam io_addr_t IC_BASE = 16'h0100;
    localparam io_addr_t TIMER_BASE = 16'h0200;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_OPS = 150;
    // Worst case per operation including idle gaps and arbitration wait
    localparam int CYCLES_PER_OP = 12;
    localparam int WATCHDOG_CYCLES = (2 * NUM_OPS + 60) * CYCLES_PER_OP;

    logic clk;
    logic reset;
    logic [NUM_MASTERS - 1:0] io_request;
    logic [NUM_MASTERS - 1:0] io_store;
    io_addr_t io_address[NUM_MASTERS];
    io_data_t io_store_data[NUM_MASTERS];
    logic [NUM_MASTERS - 1:0] io_grant;
    logic [NUM_MASTERS - 1:0] io_response_valid;
    io_data_t io_read_data[NUM_MASTERS];
    logic external_interrupt;
    logic [TOTAL_THREADS - 1:0] ic_thread_en;
    logic [TOTAL_THREADS - 1:0] ic_interrupt_pending;
    logic processor_halt;

    // Register model, updated in grant order
    logic [TOTAL_THREADS - 1:0] model_en;
    logic [NUM_INT_SOURCES - 1:0] model_trigger;
    int model_ptr;
    bit random_phase;
    int cycle;
    int error_count;
    int assertion_count;

    // Expected responses per port
    int exp_cycle_q[NUM_MASTERS][$];
    io_data_t exp_data_q[NUM_MASTERS][$];
    bit exp_check_q[NUM_MASTERS][$];
    logic [TOTAL_THREADS - 1:0] exp_en_q[NUM_MASTERS][$];

    io_subsystem #(
        .NUM_MASTERS(NUM_MASTERS),
        .IC_BASE(IC_BASE),
        .TIMER_BASE(TIMER_BASE)
    ) uut (
        .clk(clk),
        .reset(reset),
        .io_request(io_request),
        .io_store(io_store),
        .io_address(io_address),
        .io_store_data(io_store_data),
        .io_grant(io_grant),
        .io_response_valid(io_response_valid),
        .io_read_data(io_read_data),
        .external_interrupt(external_interrupt),
        .ic_thread_en(ic_thread_en),
        .ic_interrupt_pending(ic_interrupt_pending),
        .processor_halt(processor_halt)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // Apply a granted request to the model and queue its response
    task automatic record_grant(input int m);
        io_addr_t a;
        io_data_t d;
        io_data_t expected;
        bit check;

        a = io_address[m];
        d = io_store_data[m];
        expected = '0;
        check = 1'b1;
        if (io_store[m])
        begin
            if (a == IC_BASE + RESUME)
                model_en = model_en | d[TOTAL_THREADS - 1:0];
            else if (a == IC_BASE + HALT)
                model_en = model_en & ~d[TOTAL_THREADS - 1:0];
            else if (a == IC_BASE + TRIGGER)
                model_trigger = d[NUM_INT_SOURCES - 1:0];
        end
        else if (a == IC_BASE + RESUME)
            expected = io_data_t'(model_en);
        else if (a == IC_BASE + TRIGGER)
            expected = io_data_t'(model_trigger);
        else
            // Latches and count stay zero while the sources are quiet
            check = random_phase;

        exp_cycle_q[m].push_back(cycle);
        exp_data_q[m].push_back(expected);
        exp_check_q[m].push_back(check);
        exp_en_q[m].push_back(model_en);
    endtask

    task automatic check_response(input int m);
        logic [TOTAL_THREADS - 1:0] en;

        if (exp_cycle_q[m].size() == 0)
        begin
            $display("Response on port %0d without a matching grant", m);
            error_count++;
        end
        else
        begin
            en = exp_en_q[m].pop_front();
            check_value("response_cycle", cycle, exp_cycle_q[m].pop_front() + 2);
            if (exp_check_q[m].pop_front())
                check_value("io_read_data", io_read_data[m], exp_data_q[m].pop_front());
            else
                void'(exp_data_q[m].pop_front());
            check_value("ic_thread_en", ic_thread_en, en);
            check_value("processor_halt", processor_halt, en == '0);
        end
    endtask

    // Arbitration and response monitor
    always @(negedge clk)
    begin : monitor
        logic [NUM_MASTERS - 1:0] exp_grant;
        int cand;

        if (!reset)
        begin
            exp_grant = '0;
            for (int i = 0; i < NUM_MASTERS; i++)
            begin
                cand = (model_ptr + i) % NUM_MASTERS;
                if (exp_grant == '0 && io_request[cand])
                    exp_grant[cand] = 1'b1;
            end
            check_value("io_grant", io_grant, exp_grant);

            for (int m = 0; m < NUM_MASTERS; m++)
            begin
                if (io_grant[m])
                begin
                    record_grant(m);
                    model_ptr = (m + 1) % NUM_MASTERS;
                end
                if (io_response_valid[m])
                    check_response(m);
            end
        end
    end

    // Hold the request until granted, then wait for the response
    task automatic bus_access(input int m, input bit st, input io_addr_t a,
        input io_data_t d, output io_data_t rd);
        @(posedge clk);
        io_request[m] <= 1'b1;
        io_store[m] <= st;
        io_address[m] <= a;
        io_store_data[m] <= d;
        do
            @(negedge clk);
        while (!io_grant[m]);
        @(posedge clk);
        io_request[m] <= 1'b0;
        do
            @(negedge clk);
        while (!io_response_valid[m]);
        rd = io_read_data[m];
    endtask

    task automatic run_random(input int m);
        io_data_t rd;
        int op;

        for (int i = 0; i < NUM_OPS; i++)
        begin
            op = $urandom % 8;
            case (op)
                0: bus_access(m, 1'b1, IC_BASE + RESUME, $urandom, rd);
                1: bus_access(m, 1'b1, IC_BASE + HALT, $urandom, rd);
                2: bus_access(m, 1'b1, IC_BASE + TRIGGER, $urandom, rd);
                3: bus_access(m, 1'b1, IC_BASE + ACK, $urandom, rd);
                4: bus_access(m, 1'b0, IC_BASE + RESUME, '0, rd);
                5: bus_access(m, 1'b0, IC_BASE + TRIGGER, '0, rd);
                6: bus_access(m, 1'b0, IC_BASE + PENDING, '0, rd);
                // Timer kept disabled, only the periodic bit moves
                default:
                    if ($urandom % 2)
                        bus_access(m, 1'b1, TIMER_BASE + CONTROL, $urandom & 32'h2, rd);
                    else
                        bus_access(m, 1'b0, TIMER_BASE + COUNT, '0, rd);
            endcase
            repeat ($urandom % 3)
                @(posedge clk);
        end
    endtask

    task automatic test_external;
        io_data_t rd;

        // Edge type latches until acked
        bus_access(0, 1'b1, IC_BASE + TRIGGER, 32'h0, rd);
        @(posedge clk);
        external_interrupt <= 1'b1;
        @(posedge clk);
        external_interrupt <= 1'b0;
        @(negedge clk);
        check_value("ic_interrupt_pending[0]", ic_interrupt_pending[0], 1'b1);
        bus_access(0, 1'b0, IC_BASE + PENDING, '0, rd);
        check_value("pending_read", rd, 32'h2);
        check_value("ic_interrupt_pending[0]", ic_interrupt_pending[0], 1'b1);
        bus_access(0, 1'b1, IC_BASE + ACK, 32'h2, rd);
        check_value("ic_interrupt_pending[0]", ic_interrupt_pending[0], 1'b0);
        bus_access(0, 1'b0, IC_BASE + PENDING, '0, rd);
        check_value("pending_read", rd, 32'h0);

        // Level type follows the pin
        bus_access(0, 1'b1, IC_BASE + TRIGGER, 32'h2, rd);
        @(posedge clk);
        external_interrupt <= 1'b1;
        @(negedge clk);
        check_value("ic_interrupt_pending[0]", ic_interrupt_pending[0], 1'b1);
        @(posedge clk);
        external_interrupt <= 1'b0;
        @(negedge clk);
        check_value("ic_interrupt_pending[0]", ic_interrupt_pending[0], 1'b0);
        bus_access(0, 1'b1, IC_BASE + TRIGGER, 32'h0, rd);
    endtask

    task automatic test_timer;
        io_data_t rd;
        int n;
        int start;

        n = 6 + $urandom % 20;
        bus_access(0, 1'b1, TIMER_BASE + RELOAD, n, rd);
        bus_access(0, 1'b1, TIMER_BASE + CONTROL, 32'h1, rd);
        start = cycle;
        bus_access(0, 1'b0, TIMER_BASE + COUNT, '0, rd);
        check_value("count_within_reload", rd <= n, 1'b1);
        while (!ic_interrupt_pending[0] && cycle - start < n + 4)
            @(negedge clk);
        if (!ic_interrupt_pending[0])
        begin
            $display("Timer interrupt not pending within %0d cycles", n + 4);
            error_count++;
        end
        bus_access(0, 1'b0, TIMER_BASE + COUNT, '0, rd);
        check_value("count_after_expiry", rd, 32'h0);
        bus_access(0, 1'b1, IC_BASE + ACK, 32'h1, rd);
        bus_access(0, 1'b0, IC_BASE + PENDING, '0, rd);
        check_value("pending_read", rd, 32'h0);
    endtask

    initial
    begin
        void'($urandom(32'h96c0_72c8));
        reset = 1'b1;
        io_request = '0;
        io_store = '0;
        io_address = '{default: '0};
        io_store_data = '{default: '0};
        external_interrupt = 1'b0;
        model_en = TOTAL_THREADS'(1);
        model_trigger = '0;
        model_ptr = 0;
        random_phase = 1'b1;
        cycle = 0;
        error_count = 0;
        assertion_count = 0;
        repeat (2)
            @(posedge clk);
        reset <= 1'b0;

        fork
            run_random(0);
            run_random(1);
        join
        random_phase = 1'b0;
        test_external();
        test_timer();
        repeat (4)
            @(posedge clk);

        // Bound checkers count their own failures
        assertion_count = uut.arbiter.arbiter_asserts.fail_count
            + uut.ic.controller_asserts.fail_count;
        $display("Errors: %0d, assertion failures: %0d", error_count, assertion_count);
        if (error_count == 0 && assertion_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, a transaction never completed");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/io_pkg.sv
hdl/io_bus_if.sv
hdl/io_arbiter.sv
hdl/interrupt_controller.sv
hdl/interval_timer.sv
hdl/io_subsystem.sv
testbench/io_subsystem_asserts.sv
testbench/io_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  - files:
      - hdl/io_pkg.sv
      - hdl/io_bus_if.sv
      - hdl/io_arbiter.sv
      - hdl/interrupt_controller.sv
      - hdl/interval_timer.sv
      - hdl/io_subsystem.sv
  - target: test
    files:
      - testbench/io_subsystem_asserts.sv
      - testbench/io_subsystem_tb.sv
